/* Bender.yml */
package:
  name: fpga_core

sources:
  - pcie_core_pkg.sv
  - pcie_req_if.sv
  - cq_decoder.sv
  - bar_regs.sv
  - cc_encoder.sv
  - fpga_core.sv
  - target: simulation
    files:
      - tb_fpga_core.sv

/* bar_regs.sv */
/*
 * BAR execution block
 * BAR0 register window and BAR2 dword memory, with one completion slot
 */
`timescale 1ns/10ps

module bar_regs (
    input  logic        clk,
    input  logic        rst_n,
    pcie_req_if.dst     req,
    pcie_cpl_if.src     cpl,
    output logic [15:0] led_reg,
    output logic        error_pulse
);

    logic [pcie_core_pkg::DATA_W-1:0] mem [pcie_core_pkg::MEM_DEPTH];
    logic [pcie_core_pkg::DATA_W-1:0] scratch_reg;
    logic [pcie_core_pkg::DATA_W-1:0] req_count;
    logic [pcie_core_pkg::DATA_W-1:0] reg_rdata;
    logic [pcie_core_pkg::MEM_AW-1:0] mem_addr;
    logic                             req_fire;
    logic                             is_mem;
    logic                             is_bad;

    assign req.ready = !cpl.valid || cpl.ready;
    assign req_fire  = req.valid && req.ready;
    // Address wraps at the BAR2 aperture
    assign mem_addr  = req.dw_addr[pcie_core_pkg::MEM_AW-1:0];
    assign is_mem    = (req.bar_id == pcie_core_pkg::BAR_MEM);
    assign is_bad    = (req.req_class == pcie_core_pkg::REQ_BAD);

    // BAR0 read mux, unmapped offsets read zero
    always_comb begin
        case (req.dw_addr)
            pcie_core_pkg::REG_ID:        reg_rdata = pcie_core_pkg::CORE_ID;
            pcie_core_pkg::REG_LED:       reg_rdata = {16'd0, led_reg};
            pcie_core_pkg::REG_SCRATCH:   reg_rdata = scratch_reg;
            pcie_core_pkg::REG_REQ_COUNT: reg_rdata = req_count;
            default:                      reg_rdata = '0;
        endcase
    end

    // ============================================================
    // Control registers and completion slot
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpl.valid   <= 1'b0;
            led_reg     <= '0;
            scratch_reg <= '0;
            req_count   <= '0;
            error_pulse <= 1'b0;
        end else begin
            error_pulse <= req_fire && is_bad;
            if (req_fire) begin
                cpl.valid <= (req.req_class == pcie_core_pkg::REQ_RD) || (is_bad && req.bad_rd);
            end else if (cpl.ready) begin
                cpl.valid <= 1'b0;
            end
            // Counts supported requests, a read of the counter sees the old value
            if (req_fire && !is_bad) begin
                req_count <= req_count + 1'b1;
            end
            if (req_fire && req.req_class == pcie_core_pkg::REQ_WR && !is_mem) begin
                case (req.dw_addr)
                    pcie_core_pkg::REG_LED:     led_reg     <= req.data[15:0];
                    pcie_core_pkg::REG_SCRATCH: scratch_reg <= req.data;
                    default: ;
                endcase
            end
        end
    end

    // Completion payload and BAR2 memory
    always_ff @(posedge clk) begin
        if (req_fire) begin
            cpl.tag <= req.tag;
            if (is_bad) begin
                cpl.status <= pcie_core_pkg::UR;
                cpl.data   <= '0;
            end else begin
                cpl.status <= pcie_core_pkg::SC;
                cpl.data   <= is_mem ? mem[mem_addr] : reg_rdata;
            end
            if (req.req_class == pcie_core_pkg::REQ_WR && is_mem) begin
                mem[mem_addr] <= req.data;
            end
        end
    end

    // A waiting completion keeps its record until the encoder takes it
    a_cpl_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        cpl.valid && !cpl.ready |=> cpl.valid && $stable(cpl.tag) &&
                                    $stable(cpl.status) && $stable(cpl.data)
    );

endmodule

/* cc_encoder.sv */
/*
 * CC completion encoder
 * Output slot that packs a completion record into a CC beat
 */
`timescale 1ns/10ps

module cc_encoder (
    input  logic                    clk,
    input  logic                    rst_n,
    pcie_cpl_if.dst                 cpl,
    output pcie_core_pkg::cc_beat_t cc_tdata,
    output logic                    cc_tvalid,
    input  logic                    cc_tready
);

    logic cpl_fire;

    // Take a new completion when the beat is empty or leaving now
    assign cpl.ready = !cc_tvalid || cc_tready;
    assign cpl_fire  = cpl.valid && cpl.ready;

    // ============================================================
    // Output slot
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cc_tvalid <= 1'b0;
        end else if (cpl_fire) begin
            cc_tvalid <= 1'b1;
        end else if (cc_tready) begin
            cc_tvalid <= 1'b0;
        end
    end

    // Beat packing
    always_ff @(posedge clk) begin
        if (cpl_fire) begin
            cc_tdata.tag    <= cpl.tag;
            cc_tdata.status <= cpl.status;
            cc_tdata.data   <= cpl.data;
        end
    end

    // Beat is held steady under back-pressure
    a_cc_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        cc_tvalid && !cc_tready |=> cc_tvalid && $stable(cc_tdata)
    );

endmodule

/* cq_decoder.sv */
/*
 * CQ request decoder
 * Registers one CQ beat and classifies it by BAR and request type
 */
`timescale 1ns/10ps

module cq_decoder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pcie_core_pkg::cq_beat_t cq_tdata,
    input  logic                    cq_tvalid,
    output logic                    cq_tready,
    pcie_req_if.src                 req
);

    logic cq_fire;
    logic type_rd;
    logic type_wr;
    logic bar_ok;

    // Slot accepts when empty or when the held request leaves this cycle
    assign cq_tready = !req.valid || req.ready;
    assign cq_fire   = cq_tvalid && cq_tready;

    assign type_rd = (cq_tdata.req_type == pcie_core_pkg::MEM_RD);
    assign type_wr = (cq_tdata.req_type == pcie_core_pkg::MEM_WR);
    assign bar_ok  = (cq_tdata.bar_id == pcie_core_pkg::BAR_REGS) ||
                     (cq_tdata.bar_id == pcie_core_pkg::BAR_MEM);

    // ============================================================
    // Slot occupancy
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req.valid <= 1'b0;
        end else if (cq_fire) begin
            req.valid <= 1'b1;
        end else if (req.ready) begin
            req.valid <= 1'b0;
        end
    end

    // Request fields, held while the slot waits
    always_ff @(posedge clk) begin
        if (cq_fire) begin
            req.bar_id  <= cq_tdata.bar_id;
            req.dw_addr <= cq_tdata.dw_addr;
            req.tag     <= cq_tdata.tag;
            req.data    <= cq_tdata.data;
            req.bad_rd  <= type_rd && !bar_ok;
            if (bar_ok && type_rd) begin
                req.req_class <= pcie_core_pkg::REQ_RD;
            end else if (bar_ok && type_wr) begin
                req.req_class <= pcie_core_pkg::REQ_WR;
            end else begin
                req.req_class <= pcie_core_pkg::REQ_BAD;
            end
        end
    end

    // A waiting request keeps its fields until the BAR block takes it
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        req.valid && !req.ready |=> req.valid && $stable(req.req_class) &&
                                    $stable(req.bar_id) && $stable(req.dw_addr) &&
                                    $stable(req.tag) && $stable(req.data) &&
                                    $stable(req.bad_rd)
    );

endmodule

/* filelist.f */
pcie_core_pkg.sv
pcie_req_if.sv
cq_decoder.sv
bar_regs.sv
cc_encoder.sv
fpga_core.sv
tb_fpga_core.sv

/* fpga_core.sv */
/*
 * FPGA core logic
 * PCIe endpoint application with BAR0 registers and BAR2 memory
 */
`timescale 1ns/10ps

module fpga_core (
    input  logic                                  clk,
    input  logic                                  rst_n,

    // CQ input
    input  logic [pcie_core_pkg::CQ_BEAT_W-1:0]   s_axis_cq_tdata,
    input  logic                                  s_axis_cq_tvalid,
    output logic                                  s_axis_cq_tready,

    // CC output
    output logic [pcie_core_pkg::CC_BEAT_W-1:0]   m_axis_cc_tdata,
    output logic                                  m_axis_cc_tvalid,
    input  logic                                  m_axis_cc_tready,

    // GPIO
    output logic [7:0]                            led_red,
    output logic [7:0]                            led_green,
    output logic [1:0]                            led_bmc,
    output logic [1:0]                            led_exp,

    output logic                                  status_error_uncor
);

    pcie_core_pkg::cq_beat_t cq_beat;
    pcie_core_pkg::cc_beat_t cc_beat;
    logic [15:0]             led_reg;

    pcie_req_if req_bus ();
    pcie_cpl_if cpl_bus ();

    assign cq_beat         = s_axis_cq_tdata;
    assign m_axis_cc_tdata = cc_beat;

    // LED register halves, the other LEDs are fixed
    assign led_green = led_reg[7:0];
    assign led_red   = led_reg[15:8];
    assign led_bmc   = 2'b00;
    assign led_exp   = pcie_core_pkg::LED_EXP_VALUE;

    // ============================================================
    // Request pipeline
    // ============================================================
    cq_decoder i_cq_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .cq_tdata  (cq_beat),
        .cq_tvalid (s_axis_cq_tvalid),
        .cq_tready (s_axis_cq_tready),
        .req       (req_bus.src)
    );

    bar_regs i_bar_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req_bus.dst),
        .cpl         (cpl_bus.src),
        .led_reg     (led_reg),
        .error_pulse (status_error_uncor)
    );

    cc_encoder i_cc_encoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpl       (cpl_bus.dst),
        .cc_tdata  (cc_beat),
        .cc_tvalid (m_axis_cc_tvalid),
        .cc_tready (m_axis_cc_tready)
    );

endmodule

/* pcie_core_pkg.sv */
/*
 * PCIe application core package
 * Beat layouts for the CQ and CC streams, BAR and register map constants,
 * request type, completion status and request class encodings
 */
package pcie_core_pkg;

    // ============================================================
    // Field widths
    // ============================================================
    localparam int TAG_W  = 8;
    localparam int BAR_W  = 3;
    localparam int ADDR_W = 11;
    localparam int DATA_W = 32;

    // Request types carried in the CQ beat
    typedef enum logic [3:0] {
        MEM_RD = 4'd0,
        MEM_WR = 4'd1
    } req_type_e;

    // Completion status in the CC beat
    typedef enum logic [2:0] {
        SC = 3'd0,
        UR = 3'd1
    } cpl_status_e;

    // Decoded class after the CQ stage
    typedef enum logic [1:0] {
        REQ_RD,
        REQ_WR,
        REQ_BAD
    } req_class_e;

    // Raw type field, so that unknown encodings stay visible
    typedef struct packed {
        logic [3:0]        req_type;
        logic [BAR_W-1:0]  bar_id;
        logic [ADDR_W-1:0] dw_addr;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } cq_beat_t;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        cpl_status_e       status;
        logic [DATA_W-1:0] data;
    } cc_beat_t;

    localparam int CQ_BEAT_W = $bits(cq_beat_t);
    localparam int CC_BEAT_W = $bits(cc_beat_t);

    // ============================================================
    // BAR map
    // ============================================================
    localparam logic [BAR_W-1:0] BAR_REGS = 3'd0;
    localparam logic [BAR_W-1:0] BAR_MEM  = 3'd2;
    localparam int MEM_DEPTH = 64;
    localparam int MEM_AW    = $clog2(MEM_DEPTH);

    // BAR0 register indices
    localparam logic [ADDR_W-1:0] REG_ID        = 11'd0;
    localparam logic [ADDR_W-1:0] REG_LED       = 11'd1;
    localparam logic [ADDR_W-1:0] REG_SCRATCH   = 11'd2;
    localparam logic [ADDR_W-1:0] REG_REQ_COUNT = 11'd3;

    localparam logic [DATA_W-1:0] CORE_ID = 32'h0C0E_0001;

    localparam logic [1:0] LED_EXP_VALUE = 2'b11;

endpackage

/* pcie_req_if.sv */
/*
 * Stage-to-stage interfaces
 * Decoded request from the CQ decoder and completion record from the BAR block
 */
`timescale 1ns/10ps

interface pcie_req_if;
    logic                                valid;
    logic                                ready;
    pcie_core_pkg::req_class_e           req_class;
    logic [pcie_core_pkg::BAR_W-1:0]     bar_id;
    logic [pcie_core_pkg::ADDR_W-1:0]    dw_addr;
    logic [pcie_core_pkg::TAG_W-1:0]     tag;
    logic [pcie_core_pkg::DATA_W-1:0]    data;
    // Set for an unsupported request that was a read
    logic                                bad_rd;

    modport src (output valid, req_class, bar_id, dw_addr, tag, data, bad_rd, input ready);
    modport dst (input valid, req_class, bar_id, dw_addr, tag, data, bad_rd, output ready);
endinterface

interface pcie_cpl_if;
    logic                                valid;
    logic                                ready;
    logic [pcie_core_pkg::TAG_W-1:0]     tag;
    pcie_core_pkg::cpl_status_e          status;
    logic [pcie_core_pkg::DATA_W-1:0]    data;

    modport src (output valid, tag, status, data, input ready);
    modport dst (input valid, tag, status, data, output ready);
endinterface

/* tb_fpga_core.sv */
/*
 * Testbench for the PCIe endpoint application core
 * Random BAR0 and BAR2 traffic checked against a reference model of the BARs
 */
`timescale 1ns/10ps

module tb_fpga_core;

    localparam int TIMEOUT_CYCLES = 400 * 20 + 200;

    logic                                clk              = 1'b0;
    logic                                rst_n            = 1'b0;
    logic [pcie_core_pkg::CQ_BEAT_W-1:0] s_axis_cq_tdata  = '0;
    logic                                s_axis_cq_tvalid = 1'b0;
    logic                                s_axis_cq_tready;
    logic [pcie_core_pkg::CC_BEAT_W-1:0] m_axis_cc_tdata;
    logic                                m_axis_cc_tvalid;
    logic                                m_axis_cc_tready = 1'b1;
    logic [7:0]                          led_red;
    logic [7:0]                          led_green;
    logic [1:0]                          led_bmc;
    logic [1:0]                          led_exp;
    logic                                status_error_uncor;

    // Reference model state
    logic [31:0]             model_mem [pcie_core_pkg::MEM_DEPTH];
    logic [15:0]             model_led     = '0;
    logic [31:0]             model_scratch = '0;
    logic [31:0]             model_count   = '0;
    int                      bad_count     = 0;
    int                      error_pulses  = 0;
    int                      cycle_count   = 0;
    logic                    rand_ready    = 1'b0;
    int                      gap_max       = 0;
    pcie_core_pkg::cc_beat_t exp_q[$];
    string                   name_q[$];
    pcie_core_pkg::cc_beat_t cc_seen;

    fpga_core i_fpga_core (.*);

    always #5 clk = ~clk;

    // ============================================================
    // Result checks
    // ============================================================
    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_cc(input string name, input pcie_core_pkg::cc_beat_t exp,
                            input pcie_core_pkg::cc_beat_t act);
        if (act !== exp) begin
            $display("ERR %s: expected tag=%h status=%0d data=%h, actual tag=%h status=%0d data=%h",
                     name, exp.tag, exp.status, exp.data, act.tag, act.status, act.data);
            abort_run();
        end
    endtask

    task automatic check_leds(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected leds=%h, actual leds=%h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_error(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %s: expected pulses=%0d, actual pulses=%0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_port(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    // ============================================================
    // Model and stimulus
    // ============================================================
    task automatic model_accept(input pcie_core_pkg::cq_beat_t beat, input string name);
        pcie_core_pkg::cc_beat_t exp;
        logic                    bar_ok;
        logic                    is_mem;
        bar_ok = (beat.bar_id == pcie_core_pkg::BAR_REGS) ||
                 (beat.bar_id == pcie_core_pkg::BAR_MEM);
        is_mem = (beat.bar_id == pcie_core_pkg::BAR_MEM);
        exp.tag    = beat.tag;
        exp.status = pcie_core_pkg::SC;
        exp.data   = '0;
        if (bar_ok && beat.req_type == pcie_core_pkg::MEM_RD) begin
            if (is_mem) begin
                exp.data = model_mem[beat.dw_addr % pcie_core_pkg::MEM_DEPTH];
            end else begin
                case (beat.dw_addr)
                    11'd0:   exp.data = 32'h0C0E_0001;
                    11'd1:   exp.data = {16'd0, model_led};
                    11'd2:   exp.data = model_scratch;
                    11'd3:   exp.data = model_count;
                    default: exp.data = '0;
                endcase
            end
            exp_q.push_back(exp);
            name_q.push_back(name);
            model_count++;
        end else if (bar_ok && beat.req_type == pcie_core_pkg::MEM_WR) begin
            if (is_mem) begin
                model_mem[beat.dw_addr % pcie_core_pkg::MEM_DEPTH] = beat.data;
            end else if (beat.dw_addr == 11'd1) begin
                model_led = beat.data[15:0];
            end else if (beat.dw_addr == 11'd2) begin
                model_scratch = beat.data;
            end
            model_count++;
        end else begin
            bad_count++;
            // Only a read gets a completion, with UR and zero data
            if (beat.req_type == pcie_core_pkg::MEM_RD) begin
                exp.status = pcie_core_pkg::UR;
                exp_q.push_back(exp);
                name_q.push_back(name);
            end
        end
    endtask

    function automatic pcie_core_pkg::cq_beat_t make_beat(input logic [3:0] req_type,
            input logic [2:0] bar_id, input logic [10:0] dw_addr, input logic [31:0] data);
        pcie_core_pkg::cq_beat_t beat;
        beat.req_type = req_type;
        beat.bar_id   = bar_id;
        beat.dw_addr  = dw_addr;
        beat.tag      = 8'($urandom());
        beat.data     = data;
        return beat;
    endfunction

    // Starts and ends on a falling edge
    task automatic send_req(input pcie_core_pkg::cq_beat_t beat, input string name);
        int gap;
        s_axis_cq_tdata  = beat;
        s_axis_cq_tvalid = 1'b1;
        do begin
            @(posedge clk);
        end while (!s_axis_cq_tready);
        model_accept(beat, name);
        @(negedge clk);
        s_axis_cq_tvalid = 1'b0;
        gap = $urandom_range(0, gap_max);
        repeat (gap) @(negedge clk);
    endtask

    task automatic drain_pipeline();
        rand_ready = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        // Posted writes have left all three stages by now
        repeat (4) @(negedge clk);
    endtask

    // ============================================================
    // Monitors
    // ============================================================
    always @(negedge clk) begin
        m_axis_cc_tready = !rand_ready || ($urandom_range(0, 3) != 0);
    end

    always @(posedge clk) begin
        if (rst_n && status_error_uncor) begin
            error_pulses++;
        end
        if (rst_n && m_axis_cc_tvalid && m_axis_cc_tready) begin
            cc_seen = m_axis_cc_tdata;
            if (exp_q.size() == 0) begin
                $display("A completion with tag %h arrived that no request asked for", cc_seen.tag);
                abort_run();
            end else begin
                check_cc(name_q.pop_front(), exp_q.pop_front(), cc_seen);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            abort_run();
        end
    end

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        pcie_core_pkg::cq_beat_t beat;
        logic [2:0]              bar;
        logic [31:0]             wdata;
        void'($urandom(50));
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_port("reset cc_tvalid", 8'd0, {7'd0, m_axis_cc_tvalid});
        check_port("reset cq_tready", 8'd1, {7'd0, s_axis_cq_tready});
        check_port("reset led_exp", 8'd3, {6'd0, led_exp});
        check_port("reset led_bmc", 8'd0, {6'd0, led_bmc});
        check_leds("reset leds", 16'd0, {led_red, led_green});

        // ID and scratch registers
        send_req(make_beat(pcie_core_pkg::MEM_RD, 3'd0, 11'd0, '0), "id read");
        wdata = $urandom();
        send_req(make_beat(pcie_core_pkg::MEM_WR, 3'd0, 11'd2, wdata), "scratch write");
        send_req(make_beat(pcie_core_pkg::MEM_RD, 3'd0, 11'd2, '0), "scratch read");
        drain_pipeline();

        wdata = $urandom();
        send_req(make_beat(pcie_core_pkg::MEM_WR, 3'd0, 11'd1, wdata), "led write");
        drain_pipeline();
        check_leds("led write", wdata[15:0], {led_red, led_green});
        send_req(make_beat(pcie_core_pkg::MEM_RD, 3'd0, 11'd1, '0), "led read");

        // Fill BAR2 so that every later read has a known value
        for (int i = 0; i < pcie_core_pkg::MEM_DEPTH; i++) begin
            send_req(make_beat(pcie_core_pkg::MEM_WR, 3'd2, i[10:0], $urandom()), "mem fill");
        end

        rand_ready = 1'b1;
        gap_max    = 2;
        repeat (300) begin
            beat = make_beat($urandom_range(0, 1) ? pcie_core_pkg::MEM_WR : pcie_core_pkg::MEM_RD,
                             3'd2, 11'($urandom()), $urandom());
            send_req(beat, "mem random");
        end
        drain_pipeline();

        // Unsupported BARs and request types
        rand_ready = 1'b1;
        repeat (40) begin
            if ($urandom_range(0, 1) == 0) begin
                do begin
                    bar = 3'($urandom());
                end while (bar == 3'd0 || bar == 3'd2);
                beat = make_beat($urandom_range(0, 1) ? pcie_core_pkg::MEM_WR :
                                 pcie_core_pkg::MEM_RD, bar, 11'($urandom()), $urandom());
            end else begin
                beat = make_beat(4'($urandom_range(2, 15)), 3'($urandom()), 11'($urandom()),
                                 $urandom());
            end
            send_req(beat, "unsupported");
        end
        drain_pipeline();
        check_error("error pulses", bad_count, error_pulses);

        gap_max = 0;
        send_req(make_beat(pcie_core_pkg::MEM_RD, 3'd0, 11'd3, '0), "count read");
        send_req(make_beat(pcie_core_pkg::MEM_RD, 3'd0, 11'd3, '0), "count reread");
        drain_pipeline();

        $display("Simulation passed");
        $finish;
    end

endmodule
